// ==== logic/tagmem_consts.svh ====
// tagged memory size constants, included by the packages and RAM modules that need them
`ifndef TAGMEM_CONSTS_SVH
`define TAGMEM_CONSTS_SVH

// word address bits
`define TAGMEM_ADDR_WIDTH 4

// words in each RAM, always a power of two
`define TAGMEM_DEPTH (1 << `TAGMEM_ADDR_WIDTH)

`endif

// ==== logic/memTypesPkg.sv ====
// storage types shared by the RAMs, the port controller and the top level
`include "tagmem_consts.svh"

package memTypesPkg;

    // one processor data word
    typedef logic [31:0] dataWord;

    // word address into both RAMs
    typedef logic [`TAGMEM_ADDR_WIDTH-1:0] wordAddr;

    // per byte lane write enables, bit 0 is the low byte
    typedef logic [3:0] byteMask;

endpackage

// ==== logic/portCtrlPkg.sv ====
// port controller types, used by the scrub and serve logic of memoryPort
`include "tagmem_consts.svh"

package portCtrlPkg;

    // controller modes, scrub runs once after reset
    typedef enum logic {
        Scrubbing,
        Serving
    } portState;

    // one extra bit so the walk can see its own end
    typedef logic [`TAGMEM_ADDR_WIDTH:0] scrubCount;

endpackage

// ==== logic/byteLaneRam.sv ====
// 32-bit single-port data RAM with byte lane write mask, instantiated by taggedMemory
`timescale 1ns/1ps
`include "tagmem_consts.svh"

module byteLaneRam (
    input  logic                 clk,
    input  logic                 write,
    input  memTypesPkg::byteMask mask,
    input  memTypesPkg::wordAddr addr,
    input  memTypesPkg::dataWord wdata,
    output memTypesPkg::dataWord rdata
);

    memTypesPkg::dataWord mem [0:`TAGMEM_DEPTH-1];

    // old word comes out one cycle later, also on a write
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

    // each lane is replaced only when its mask bit is set
    always_ff @(posedge clk) begin
        if (write) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (mask[lane]) begin
                    mem[addr][lane*8 +: 8] <= wdata[lane*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== logic/grubbyTagRam.sv ====
// one tag bit per word, applies the grubby update rule, instantiated by taggedMemory
`timescale 1ns/1ps
`include "tagmem_consts.svh"

module grubbyTagRam (
    input  logic                 clk,
    input  logic                 write,
    input  memTypesPkg::byteMask mask,
    input  memTypesPkg::wordAddr addr,
    input  logic                 wgrubby,
    output logic                 rgrubby
);

    logic tags [0:`TAGMEM_DEPTH-1];
    logic anyLane;
    logic newTag;

    // a partial write always leaves the word grubby
    assign anyLane = |mask;
    assign newTag  = (mask != 4'b1111) | wgrubby;

    always_ff @(posedge clk) begin
        rgrubby <= tags[addr];
    end

    // zero mask touches no lane and so keeps the old tag
    always_ff @(posedge clk) begin
        if (write && anyLane) begin
            tags[addr] <= newTag;
        end
    end

endmodule

// ==== logic/memoryPort.sv ====
// request port controller: post-reset scrub, RAM control mux and response valid
`timescale 1ns/1ps
`include "tagmem_consts.svh"

module memoryPort (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 valid,
    input  logic                 write,
    input  memTypesPkg::byteMask wmask,
    input  memTypesPkg::dataWord wdata,
    input  logic                 wgrubby,
    input  memTypesPkg::wordAddr addr,
    output logic                 ready,
    output logic                 rvalid,
    output logic                 ramWrite,
    output memTypesPkg::byteMask ramMask,
    output memTypesPkg::wordAddr ramAddr,
    output memTypesPkg::dataWord ramWdata,
    output logic                 ramWgrubby
);

    portCtrlPkg::portState  state;
    portCtrlPkg::scrubCount scrubCnt;
    portCtrlPkg::scrubCount scrubNext;
    logic                   scrubbing;
    logic                   accepted;
    logic                   scrubDone;

    assign scrubbing = (state == portCtrlPkg::Scrubbing);
    assign ready     = (state == portCtrlPkg::Serving);
    assign accepted  = valid & ready;

    // top bit of the next count marks the last scrub address
    assign scrubNext = scrubCnt + portCtrlPkg::scrubCount'(1);
    assign scrubDone = scrubNext[`TAGMEM_ADDR_WIDTH];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= portCtrlPkg::Scrubbing;
            scrubCnt <= '0;
        end else begin
            case (state)
                portCtrlPkg::Scrubbing: begin
                    scrubCnt <= scrubNext;
                    if (scrubDone) begin
                        state <= portCtrlPkg::Serving;
                    end
                end
                portCtrlPkg::Serving: begin
                    // stays here until the next reset
                    state <= portCtrlPkg::Serving;
                end
                default: begin
                    state <= portCtrlPkg::Scrubbing;
                end
            endcase
        end
    end

    // one response per accepted request, reads and writes alike
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rvalid <= 1'b0;
        end else begin
            rvalid <= accepted;
        end
    end

    // scrub writes zero data and a grubby tag into every word
    always_comb begin
        if (scrubbing) begin
            ramWrite   = 1'b1;
            ramMask    = '1;
            ramAddr    = scrubCnt[`TAGMEM_ADDR_WIDTH-1:0];
            ramWdata   = '0;
            ramWgrubby = 1'b1;
        end else begin
            ramWrite   = accepted & write;
            ramMask    = wmask;
            ramAddr    = addr;
            ramWdata   = wdata;
            ramWgrubby = wgrubby;
        end
    end

endmodule

// ==== logic/taggedMemory.sv ====
// top level of the tagged word memory, connects the port controller to data and tag RAMs
`timescale 1ns/1ps

module taggedMemory (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 valid,
    input  logic                 write,
    input  memTypesPkg::byteMask wmask,
    input  memTypesPkg::dataWord wdata,
    input  logic                 wgrubby,
    input  memTypesPkg::wordAddr addr,
    output logic                 ready,
    output logic                 rvalid,
    output memTypesPkg::dataWord rdata,
    output logic                 rgrubby
);

    logic                 ramWrite;
    memTypesPkg::byteMask ramMask;
    memTypesPkg::wordAddr ramAddr;
    memTypesPkg::dataWord ramWdata;
    logic                 ramWgrubby;

    memoryPort memoryPort_i (
        .clk        (clk),
        .arstN      (arstN),
        .valid      (valid),
        .write      (write),
        .wmask      (wmask),
        .wdata      (wdata),
        .wgrubby    (wgrubby),
        .addr       (addr),
        .ready      (ready),
        .rvalid     (rvalid),
        .ramWrite   (ramWrite),
        .ramMask    (ramMask),
        .ramAddr    (ramAddr),
        .ramWdata   (ramWdata),
        .ramWgrubby (ramWgrubby)
    );

    // both RAMs see the same address, mask and write strobe
    byteLaneRam byteLaneRam_i (
        .clk   (clk),
        .write (ramWrite),
        .mask  (ramMask),
        .addr  (ramAddr),
        .wdata (ramWdata),
        .rdata (rdata)
    );

    grubbyTagRam grubbyTagRam_i (
        .clk     (clk),
        .write   (ramWrite),
        .mask    (ramMask),
        .addr    (ramAddr),
        .wgrubby (ramWgrubby),
        .rgrubby (rgrubby)
    );

endmodule

// ==== tb/taggedMemoryTb.sv ====
// self-checking testbench that drives taggedMemory from tagmem.f with taggedMemoryTb as top
`timescale 1ns/1ps
`include "tagmem_consts.svh"

module taggedMemoryTb;

    // one request per row with rnd picking fresh random data when the row is applied
    typedef struct packed {
        logic                 valid;
        logic                 write;
        memTypesPkg::byteMask mask;
        memTypesPkg::wordAddr addr;
        logic                 grubby;
        logic                 rnd;
        memTypesPkg::dataWord data;
    } stimRow;

    logic                 clk;
    logic                 arstN;
    logic                 valid;
    logic                 write;
    memTypesPkg::byteMask wmask;
    memTypesPkg::dataWord wdata;
    logic                 wgrubby;
    memTypesPkg::wordAddr addr;
    logic                 ready;
    logic                 rvalid;
    memTypesPkg::dataWord rdata;
    logic                 rgrubby;

    stimRow               stimTable [$];
    memTypesPkg::dataWord modelData [0:`TAGMEM_DEPTH-1];
    logic                 modelTag [0:`TAGMEM_DEPTH-1];
    integer               seed = 32'hc2877f83;
    int                   cycleCount = 0;
    int                   timeoutLimit = 0;

    taggedMemory taggedMemory_i (
        .clk     (clk),
        .arstN   (arstN),
        .valid   (valid),
        .write   (write),
        .wmask   (wmask),
        .wdata   (wdata),
        .wgrubby (wgrubby),
        .addr    (addr),
        .ready   (ready),
        .rvalid  (rvalid),
        .rdata   (rdata),
        .rgrubby (rgrubby)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic addRow(input logic v, input logic w, input memTypesPkg::byteMask m,
                          input memTypesPkg::wordAddr a, input logic g, input logic r,
                          input memTypesPkg::dataWord d);
        stimTable.push_back('{v, w, m, a, g, r, d});
    endtask

    task automatic buildTable();
        logic [31:0] r;
        for (int a = 0; a < `TAGMEM_DEPTH; a++) begin
            addRow(1'b1, 1'b0, 4'h0, memTypesPkg::wordAddr'(a), 1'b0, 1'b0, 32'h0);
        end
        addRow(1'b1, 1'b1, 4'hf, 3, 1'b0, 1'b0, 32'hdeadbeef);
        addRow(1'b1, 1'b0, 4'h0, 3, 1'b0, 1'b0, 32'h0);
        addRow(1'b1, 1'b1, 4'hf, 5, 1'b1, 1'b0, 32'h12345678);
        addRow(1'b1, 1'b0, 4'h0, 5, 1'b0, 1'b0, 32'h0);
        // partial write on a clean word must make it grubby again
        addRow(1'b1, 1'b1, 4'b0010, 3, 1'b0, 1'b0, 32'haabbccdd);
        addRow(1'b1, 1'b0, 4'h0, 3, 1'b0, 1'b0, 32'h0);
        addRow(1'b1, 1'b1, 4'hf, 7, 1'b0, 1'b0, 32'h0badf00d);
        addRow(1'b1, 1'b1, 4'h0, 7, 1'b1, 1'b0, 32'hffffffff);
        addRow(1'b1, 1'b0, 4'h0, 7, 1'b0, 1'b0, 32'h0);
        addRow(1'b0, 1'b1, 4'hf, 7, 1'b0, 1'b0, 32'h0);
        addRow(1'b1, 1'b0, 4'h0, 7, 1'b0, 1'b0, 32'h0);
        for (int i = 0; i < 32; i++) begin
            r = $random(seed);
            addRow(r[2:0] != 3'd0, r[3], r[7:4], r[8 +: `TAGMEM_ADDR_WIDTH], r[16], 1'b1, 32'h0);
        end
        for (int a = 0; a < `TAGMEM_DEPTH; a++) begin
            addRow(1'b1, 1'b0, 4'h0, memTypesPkg::wordAddr'(a), 1'b0, 1'b0, 32'h0);
        end
    endtask

    // only lanes with their mask bit set take the new byte
    function automatic memTypesPkg::dataWord mergeBytes(input memTypesPkg::dataWord oldWord,
                                                        input memTypesPkg::dataWord newWord,
                                                        input memTypesPkg::byteMask m);
        memTypesPkg::dataWord laneBits;
        laneBits = {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
        return (oldWord & ~laneBits) | (newWord & laneBits);
    endfunction

    task automatic checkResponse(input logic expValid, input memTypesPkg::dataWord expData,
                                 input logic expTag);
        assert (ready === 1'b1) else
            failRun($sformatf("Error at time %0t: ready expected 1, got %b", $time, ready));
        assert (rvalid === expValid) else
            failRun($sformatf("Error at time %0t: rvalid expected %b, got %b",
                              $time, expValid, rvalid));
        if (expValid) begin
            assert (rdata === expData) else
                failRun($sformatf("Error at time %0t: rdata expected %h, got %h",
                                  $time, expData, rdata));
            assert (rgrubby === expTag) else
                failRun($sformatf("Error at time %0t: rgrubby expected %b, got %b",
                                  $time, expTag, rgrubby));
        end
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > timeoutLimit) begin
            failRun($sformatf("Timeout: the run did not finish within %0d clock cycles",
                              timeoutLimit));
        end
    end

    initial begin
        stimRow               row;
        int                   edges;
        logic                 expValid;
        memTypesPkg::dataWord expData;
        logic                 expTag;

        arstN   = 1'b0;
        valid   = 1'b0;
        write   = 1'b0;
        wmask   = '0;
        wdata   = '0;
        wgrubby = 1'b0;
        addr    = '0;

        buildTable();
        timeoutLimit = `TAGMEM_DEPTH + stimTable.size() + 20;

        // model starts as the scrub leaves the memory
        for (int a = 0; a < `TAGMEM_DEPTH; a++) begin
            modelData[a] = '0;
            modelTag[a]  = 1'b1;
        end

        // a read request is held through reset and scrub and must not be answered
        repeat (4) begin
            @(negedge clk);
            valid = 1'b1;
            assert (ready === 1'b0 && rvalid === 1'b0) else
                failRun($sformatf("Error at time %0t: ready/rvalid expected 0/0, got %b/%b",
                                  $time, ready, rvalid));
        end
        arstN = 1'b1;

        edges = 0;
        while (ready !== 1'b1) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            assert (rvalid === 1'b0) else
                failRun($sformatf("Error at time %0t: rvalid expected 0, got %b",
                                  $time, rvalid));
        end
        assert (edges == `TAGMEM_DEPTH) else
            failRun($sformatf("Error at time %0t: ready rise edge expected %0d, got %0d",
                              $time, `TAGMEM_DEPTH, edges));
        valid = 1'b0;

        for (int i = 0; i < stimTable.size(); i++) begin
            row = stimTable[i];
            if (row.rnd) begin
                row.data = $random(seed);
            end
            valid   = row.valid;
            write   = row.write;
            wmask   = row.mask;
            wdata   = row.data;
            wgrubby = row.grubby;
            addr    = row.addr;

            // response carries the word as it was before this access
            expValid = row.valid;
            expData  = modelData[row.addr];
            expTag   = modelTag[row.addr];
            if (row.valid && row.write) begin
                modelData[row.addr] = mergeBytes(modelData[row.addr], row.data, row.mask);
                if (row.mask != 4'h0) begin
                    // only a full clean write leaves the word clean
                    modelTag[row.addr] = !(row.mask == 4'hf && !row.grubby);
                end
            end

            @(negedge clk);
            checkResponse(expValid, expData, expTag);
        end

        valid = 1'b0;
        @(negedge clk);
        checkResponse(1'b0, '0, 1'b0);

        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== tagmem.f ====
+incdir+logic
logic/memTypesPkg.sv
logic/portCtrlPkg.sv
logic/byteLaneRam.sv
logic/grubbyTagRam.sv
logic/memoryPort.sv
logic/taggedMemory.sv
tb/taggedMemoryTb.sv
